//--- files.f
+incdir+.
mem_chip_addr_pkg.sv
mem_chip_bus_pkg.sv
mem_chip_apb_port.sv
mem_chip_addr_decode.sv
mem_chip_spm.sv
mem_chip_periph_regs.sv
mem_chip.sv
tb_mem_chip.sv

//--- mem_chip.sv
/*
 * Memory chip top level
 * APB port, chip ID address decoder, scratchpad and peripheral registers
 */
`default_nettype none

module mem_chip
  import mem_chip_addr_pkg::*;
  import mem_chip_bus_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  chip_id_t       chip_id_i,
  input  bus_addr_t      paddr_i,
  input  logic           psel_i,
  input  logic           penable_i,
  input  logic           pwrite_i,
  input  word_t          pwdata_i,
  input  strb_t          pstrb_i,
  output word_t          prdata_o,
  output logic           pready_o,
  output logic           pslverr_o,
  output div_ratio_vec_t div_ratio_o
);

  // Latched chip ID
  chip_id_t    chip_id;
  target_req_t port_req;
  target_rsp_t port_rsp;
  target_req_t spm_req;
  target_rsp_t spm_rsp;
  target_req_t reg_req;
  target_rsp_t reg_rsp;

  mem_chip_apb_port i_apb_port (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .chip_id_i (chip_id_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .rsp_i     (port_rsp),
    .req_o     (port_req),
    .chip_id_o (chip_id),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  mem_chip_addr_decode i_addr_decode (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .chip_id_i (chip_id),
    .paddr_i   (paddr_i),
    .req_i     (port_req),
    .spm_rsp_i (spm_rsp),
    .reg_rsp_i (reg_rsp),
    .spm_req_o (spm_req),
    .reg_req_o (reg_req),
    .rsp_o     (port_rsp)
  );

  mem_chip_spm i_spm (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (spm_req),
    .rsp_o  (spm_rsp)
  );

  mem_chip_periph_regs i_periph_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .chip_id_i   (chip_id),
    .req_i       (reg_req),
    .rsp_o       (reg_rsp),
    .div_ratio_o (div_ratio_o)
  );

endmodule

`default_nettype wire

//--- mem_chip_addr_decode.sv
/*
 * Address decoder of the memory chip
 * Checks the chip ID byte, steers requests to a target or answers with an error
 */
`default_nettype none

`include "mem_chip_cfg.svh"

module mem_chip_addr_decode
  import mem_chip_addr_pkg::*;
  import mem_chip_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  chip_id_t    chip_id_i,
  input  bus_addr_t   paddr_i,
  input  target_req_t req_i,
  input  target_rsp_t spm_rsp_i,
  input  target_rsp_t reg_rsp_i,
  output target_req_t spm_req_o,
  output target_req_t reg_req_o,
  output target_rsp_t rsp_o
);

  localparam local_addr_t SpmBase = `MEM_CHIP_SPM_BASE;
  localparam local_addr_t SpmLast = `MEM_CHIP_SPM_BASE + `MEM_CHIP_SPM_BYTES - 1;
  localparam local_addr_t RegBase = `MEM_CHIP_REG_BASE;
  localparam local_addr_t RegLast = `MEM_CHIP_REG_BASE + `MEM_CHIP_REG_BYTES - 1;

  logic chip_match;
  logic spm_hit;
  logic reg_hit;
  logic miss;
  logic err_q;

  // Top address byte selects the chip
  assign chip_match = paddr_i[`MEM_CHIP_ADDR_W-1 -: `MEM_CHIP_CHIP_ID_W] == chip_id_i;

  assign spm_hit = chip_match && (req_i.addr >= SpmBase) && (req_i.addr <= SpmLast);
  assign reg_hit = chip_match && (req_i.addr >= RegBase) && (req_i.addr <= RegLast);
  assign miss    = req_i.valid && !spm_hit && !reg_hit;

  always_comb begin
    spm_req_o       = req_i;
    spm_req_o.valid = req_i.valid && spm_hit;
    reg_req_o       = req_i;
    reg_req_o.valid = req_i.valid && reg_hit;
  end

  // Misses answer with the same latency as a target
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= miss;
    end
  end

  always_comb begin
    if (spm_rsp_i.valid) begin
      rsp_o = spm_rsp_i;
    end else if (reg_rsp_i.valid) begin
      rsp_o = reg_rsp_i;
    end else begin
      rsp_o.valid = err_q;
      rsp_o.rdata = '0;
      rsp_o.err   = err_q;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(spm_req_o.valid && reg_req_o.valid));

  // Port, decoder and targets together keep the one cycle latency
  assert property (@(posedge clk_i) disable iff (!rst_ni) req_i.valid |=> rsp_o.valid);

endmodule

`default_nettype wire

//--- mem_chip_addr_pkg.sv
/*
 * Address map types of the memory chip
 * Chip ID, bus and local addresses, target word indices
 */
`default_nettype none

`include "mem_chip_cfg.svh"

package mem_chip_addr_pkg;

  typedef logic [`MEM_CHIP_CHIP_ID_W-1:0] chip_id_t;
  typedef logic [`MEM_CHIP_ADDR_W-1:0]    bus_addr_t;

  // Address below the chip ID byte
  typedef logic [`MEM_CHIP_LOCAL_W-1:0]   local_addr_t;

  // Word indices inside the two targets
  typedef logic [$clog2(`MEM_CHIP_SPM_BYTES/(`MEM_CHIP_DATA_W/8))-1:0] spm_index_t;
  typedef logic [2:0] reg_index_t;

  typedef logic [`MEM_CHIP_DIV_W-1:0] div_ratio_t;
  typedef div_ratio_t [`MEM_CHIP_NUM_CLK-1:0] div_ratio_vec_t;

endpackage

`default_nettype wire

//--- mem_chip_apb_port.sv
/*
 * APB slave port of the memory chip
 * Issues one target request per transfer and latches the chip ID in reset
 */
`default_nettype none

module mem_chip_apb_port
  import mem_chip_addr_pkg::*;
  import mem_chip_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  chip_id_t    chip_id_i,
  input  bus_addr_t   paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  word_t       pwdata_i,
  input  strb_t       pstrb_i,
  input  target_rsp_t rsp_i,
  output target_req_t req_o,
  output chip_id_t    chip_id_o,
  output word_t       prdata_o,
  output logic        pready_o,
  output logic        pslverr_o
);

  apb_state_e state_q, state_d;
  chip_id_t   chip_id_q;
  logic       respond;

  //////////////////////////////////////////////////
  // Chip ID latch
  //////////////////////////////////////////////////

  // Follows the pins while reset is held, frozen afterwards
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      chip_id_q <= chip_id_i;
    end
  end

  assign chip_id_o = chip_id_q;

  //////////////////////////////////////////////////
  // Transfer FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        // Setup cycle seen
        if (psel_i && !penable_i) begin
          state_d = ACCESS;
        end
      end
      ACCESS: begin
        if (psel_i && penable_i) begin
          state_d = RESPOND;
        end else begin
          state_d = IDLE;
        end
      end
      RESPOND: begin
        if (rsp_i.valid) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Master holds its inputs through the access phase
  always_comb begin
    req_o.valid = (state_q == ACCESS) && psel_i && penable_i;
    req_o.write = pwrite_i;
    req_o.addr  = paddr_i[$bits(local_addr_t)-1:0];
    req_o.wdata = pwdata_i;
    req_o.strb  = pstrb_i;
  end

  // Second access cycle completes the transfer
  assign respond   = (state_q == RESPOND) && rsp_i.valid;
  assign pready_o  = respond;
  assign prdata_o  = respond ? rsp_i.rdata : '0;
  assign pslverr_o = respond && rsp_i.err;

  assert property (@(posedge clk_i) disable iff (!rst_ni) penable_i |-> psel_i)
    else $error("APB penable asserted without psel");

endmodule

`default_nettype wire

//--- mem_chip_bus_pkg.sv
/*
 * Internal bus types of the memory chip
 * Target request and response structs, APB slave states
 */
`default_nettype none

`include "mem_chip_cfg.svh"

package mem_chip_bus_pkg;
  import mem_chip_addr_pkg::*;

  typedef logic [`MEM_CHIP_DATA_W-1:0]   word_t;
  typedef logic [`MEM_CHIP_DATA_W/8-1:0] strb_t;

  // One word access towards a target
  typedef struct packed {
    logic        valid;
    logic        write;
    local_addr_t addr;
    word_t       wdata;
    strb_t       strb;
  } target_req_t;

  // Answer of a target, one cycle after its request
  typedef struct packed {
    logic  valid;
    word_t rdata;
    logic  err;
  } target_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESPOND
  } apb_state_e;

endpackage

`default_nettype wire

//--- mem_chip_cfg.svh
/*
 * Memory chip configuration
 * Bus widths, address windows and clock divider reset values
 */
`ifndef MEM_CHIP_CFG_SVH
`define MEM_CHIP_CFG_SVH

// Bus widths
`define MEM_CHIP_ADDR_W 32
`define MEM_CHIP_DATA_W 32
`define MEM_CHIP_CHIP_ID_W 8
`define MEM_CHIP_LOCAL_W 24

// Local address windows below the chip ID byte
`define MEM_CHIP_SPM_BASE 24'h700000
`define MEM_CHIP_SPM_BYTES 1024
`define MEM_CHIP_REG_BASE 24'h007000
`define MEM_CHIP_REG_BYTES 4096

// Clock divider channels
`define MEM_CHIP_NUM_CLK 5
`define MEM_CHIP_DIV_W 8
`define MEM_CHIP_DIV_DEFAULT_0 4
`define MEM_CHIP_DIV_DEFAULT_OTHER 1

`endif

//--- mem_chip_periph_regs.sv
/*
 * Peripheral register block
 * Clock division ratios with reset defaults and a read-only chip ID
 */
`default_nettype none

`include "mem_chip_cfg.svh"

module mem_chip_periph_regs
  import mem_chip_addr_pkg::*;
  import mem_chip_bus_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  chip_id_t       chip_id_i,
  input  target_req_t    req_i,
  output target_rsp_t    rsp_o,
  output div_ratio_vec_t div_ratio_o
);

  localparam int unsigned IdxLsb = $clog2(`MEM_CHIP_DATA_W / 8);
  localparam int unsigned IdxMsb = IdxLsb + $bits(reg_index_t) - 1;
  localparam int unsigned OffMsb = $clog2(`MEM_CHIP_REG_BYTES) - 1;
  // Chip ID sits right after the last ratio
  localparam reg_index_t ChipIdIdx = reg_index_t'(`MEM_CHIP_NUM_CLK);

  div_ratio_vec_t div_q;
  word_t          rdata_d;
  word_t          rdata_q;
  logic           valid_q;
  logic           mapped;
  logic           div_we;
  reg_index_t     idx;

  assign idx = req_i.addr[IdxMsb:IdxLsb];

  // Offsets beyond the index range decode to nothing
  assign mapped = req_i.addr[OffMsb:IdxMsb+1] == '0;

  assign div_we = req_i.valid && req_i.write && req_i.strb[0] && mapped && (idx < ChipIdIdx);

  //////////////////////////////////////////////////
  // Division ratios
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < `MEM_CHIP_NUM_CLK; i++) begin
        div_q[i] <= (i == 0) ? div_ratio_t'(`MEM_CHIP_DIV_DEFAULT_0)
                             : div_ratio_t'(`MEM_CHIP_DIV_DEFAULT_OTHER);
      end
    end else if (div_we) begin
      div_q[idx] <= req_i.wdata[`MEM_CHIP_DIV_W-1:0];
    end
  end

  assign div_ratio_o = div_q;

  //////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    if (mapped && (idx < ChipIdIdx)) begin
      rdata_d = word_t'(div_q[idx]);
    end else if (mapped && (idx == ChipIdIdx)) begin
      rdata_d = word_t'(chip_id_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  assign rsp_o = '{valid: valid_q, rdata: rdata_q, err: 1'b0};

endmodule

`default_nettype wire

//--- mem_chip_spm.sv
/*
 * Scratchpad memory with byte strobes and a registered read port
 */
`default_nettype none

`include "mem_chip_cfg.svh"

module mem_chip_spm
  import mem_chip_addr_pkg::*;
  import mem_chip_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  target_req_t req_i,
  output target_rsp_t rsp_o
);

  localparam int unsigned NumWords = `MEM_CHIP_SPM_BYTES / (`MEM_CHIP_DATA_W / 8);
  localparam int unsigned IdxLsb   = $clog2(`MEM_CHIP_DATA_W / 8);
  localparam local_addr_t SpmBase  = `MEM_CHIP_SPM_BASE;
  localparam local_addr_t SpmLast  = `MEM_CHIP_SPM_BASE + `MEM_CHIP_SPM_BYTES - 1;

  word_t      mem_q [NumWords];
  word_t      rdata_q;
  logic       valid_q;
  spm_index_t idx;

  // Window is size aligned so the low bits index it directly
  assign idx = req_i.addr[IdxLsb +: $bits(spm_index_t)];

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (req_i.write) begin
        for (int b = 0; b < $bits(strb_t); b++) begin
          if (req_i.strb[b]) begin
            mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
      rdata_q <= mem_q[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  assign rsp_o = '{valid: valid_q, rdata: rdata_q, err: 1'b0};

  // Decoder only forwards addresses of this window
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i.valid |-> (req_i.addr >= SpmBase) && (req_i.addr <= SpmLast));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the memory chip testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_chip -f files.f -o sim_mem_chip

./obj_dir/sim_mem_chip | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

//--- tb_mem_chip.sv
/*
 * Testbench of the memory chip
 * LFSR driven APB transfers checked against a model of scratchpad and registers
 */
`default_nettype none

module tb_mem_chip
  import mem_chip_addr_pkg::*;
  import mem_chip_bus_pkg::*;
();

  localparam int unsigned clk_period      = 20;
  localparam int unsigned reset_cycles    = 10;
  localparam int unsigned num_transfers   = 400;
  localparam int unsigned num_random      = 360;
  localparam int unsigned cycles_per_xfer = 4;

  // Address map as seen from outside
  localparam chip_id_t    model_chip_id = 8'h5A;
  localparam chip_id_t    late_chip_id  = 8'hA5;
  localparam local_addr_t spm_base      = 24'h700000;
  localparam local_addr_t reg_base      = 24'h007000;
  localparam local_addr_t hole_base     = 24'h300000;

  logic           clk;
  logic           rst_n;
  chip_id_t       chip_id;
  bus_addr_t      paddr;
  logic           psel;
  logic           penable;
  logic           pwrite;
  word_t          pwdata;
  strb_t          pstrb;
  word_t          prdata;
  logic           pready;
  logic           pslverr;
  div_ratio_vec_t div_ratio;

  word_t       model_mem [256];
  strb_t       model_known [256];
  div_ratio_t  model_div [5];
  logic [15:0] lfsr = 16'd14;

  mem_chip mem_chip_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .chip_id_i   (chip_id),
    .paddr_i     (paddr),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .pwdata_i    (pwdata),
    .pstrb_i     (pstrb),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .div_ratio_o (div_ratio)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Taps 16, 14, 13, 11
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic word_t byte_mask(input strb_t known);
    word_t mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{known[b]}};
    end
    return mask;
  endfunction

  function automatic word_t expected_reg(input logic [9:0] off);
    word_t value;
    value = '0;
    if (off < 10'd5) begin
      value = word_t'(model_div[off[2:0]]);
    end else if (off == 10'd5) begin
      value = word_t'(model_chip_id);
    end
    return value;
  endfunction

  task automatic stop_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Fail at %0t: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
    stop_run();
  endtask

  task automatic report_problem(input string what);
    $display("Error at %0t: %s", $time, what);
    stop_run();
  endtask

  task automatic check_ratios();
    for (int i = 0; i < 5; i++) begin
      assert (div_ratio[i] == model_div[i])
        else report_mismatch($sformatf("div_ratio_o[%0d]", i), 32'(model_div[i]),
                             32'(div_ratio[i]));
    end
  endtask

  //////////////////////////////////////////////////
  // APB transfer with timing checks
  //////////////////////////////////////////////////

  task automatic apb_xfer(input bus_addr_t addr, input logic write, input word_t wdata,
                          input strb_t strb, output word_t rdata, output logic err);
    int cycles;
    if (take_bits(1) != 0) begin
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
    end
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    paddr   <= addr;
    pwrite  <= write;
    pwdata  <= wdata;
    pstrb   <= strb;
    @(posedge clk);
    penable <= 1'b1;
    cycles = 1;
    @(negedge clk);
    assert (!pready) else report_mismatch("pready_o", 32'd0, 32'(pready));
    assert (!pslverr) else report_mismatch("pslverr_o", 32'd0, 32'(pslverr));
    while (!pready && cycles < 4) begin
      @(negedge clk);
      cycles++;
    end
    assert (pready) else report_problem("pready_o never rose during the access phase");
    assert (cycles == 2) else report_mismatch("access cycles", 32'd2, 32'(cycles));
    rdata = prdata;
    err   = pslverr;
  endtask

  //////////////////////////////////////////////////
  // Accesses per target
  //////////////////////////////////////////////////

  function automatic bus_addr_t spm_addr(input spm_index_t idx);
    return {model_chip_id, spm_base + local_addr_t'({idx, 2'b00})};
  endfunction

  function automatic bus_addr_t reg_addr(input logic [9:0] off);
    return {model_chip_id, reg_base + local_addr_t'({off, 2'b00})};
  endfunction

  task automatic spm_write(input spm_index_t idx);
    word_t data;
    strb_t strb;
    word_t rdata;
    logic  err;
    data = take_bits(32);
    strb = strb_t'(take_bits(4));
    apb_xfer(spm_addr(idx), 1'b1, data, strb, rdata, err);
    assert (!err) else report_mismatch("pslverr_o", 32'd0, 32'(err));
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model_mem[idx][8*b +: 8] = data[8*b +: 8];
        model_known[idx][b]      = 1'b1;
      end
    end
  endtask

  task automatic spm_read(input spm_index_t idx);
    word_t rdata;
    word_t mask;
    logic  err;
    apb_xfer(spm_addr(idx), 1'b0, take_bits(32), 4'hF, rdata, err);
    assert (!err) else report_mismatch("pslverr_o", 32'd0, 32'(err));
    // Bytes never written hold no defined value
    mask = byte_mask(model_known[idx]);
    assert ((rdata & mask) == (model_mem[idx] & mask))
      else report_mismatch($sformatf("prdata_o of word %0d", idx), model_mem[idx] & mask,
                           rdata & mask);
  endtask

  task automatic reg_write(input logic [9:0] off);
    word_t data;
    strb_t strb;
    word_t rdata;
    logic  err;
    data = take_bits(32);
    strb = strb_t'(take_bits(4));
    apb_xfer(reg_addr(off), 1'b1, data, strb, rdata, err);
    assert (!err) else report_mismatch("pslverr_o", 32'd0, 32'(err));
    if (off < 10'd5 && strb[0]) begin
      model_div[off[2:0]] = data[7:0];
    end
  endtask

  task automatic reg_read(input logic [9:0] off);
    word_t rdata;
    logic  err;
    apb_xfer(reg_addr(off), 1'b0, take_bits(32), 4'hF, rdata, err);
    assert (!err) else report_mismatch("pslverr_o", 32'd0, 32'(err));
    assert (rdata == expected_reg(off))
      else report_mismatch($sformatf("prdata_o of register %0d", off), expected_reg(off), rdata);
  endtask

  task automatic bad_access();
    local_addr_t target;
    bus_addr_t   addr;
    word_t       rdata;
    logic        err;
    // Words that the sweep and later reads look at
    if (take_bits(1) != 0) begin
      target = reg_base + local_addr_t'({3'(take_bits(3)), 2'b00});
    end else begin
      target = spm_base + local_addr_t'({spm_index_t'(take_bits(4) * 32'd17), 2'b00});
    end
    if (take_bits(1) != 0) begin
      // Any other top byte, the pins' late value included
      addr = {model_chip_id ^ chip_id_t'(take_bits(8) | 32'd1), target};
    end else begin
      addr = {model_chip_id, hole_base | (target & 24'h000FFF)};
    end
    apb_xfer(addr, take_bits(1) != 0, take_bits(32), strb_t'(take_bits(4)), rdata, err);
    assert (err) else report_mismatch("pslverr_o", 32'd1, 32'(err));
    assert (rdata == '0) else report_mismatch("prdata_o", 32'd0, rdata);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [2:0] kind;
    rst_n   = 1'b0;
    chip_id = model_chip_id;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    pstrb   = '0;
    for (int i = 0; i < 256; i++) begin
      model_known[i] = '0;
    end
    model_div[0] = 8'd4;
    for (int i = 1; i < 5; i++) begin
      model_div[i] = 8'd1;
    end

    repeat (reset_cycles) @(posedge clk);
    rst_n   <= 1'b1;
    chip_id <= late_chip_id;
    @(negedge clk);
    assert (!pready) else report_mismatch("pready_o", 32'd0, 32'(pready));
    assert (!pslverr) else report_mismatch("pslverr_o", 32'd0, 32'(pslverr));
    assert (prdata == '0) else report_mismatch("prdata_o", 32'd0, prdata);
    check_ratios();
    reg_read(10'd5);

    for (int n = 0; n < num_random; n++) begin
      kind = 3'(take_bits(3));
      case (kind)
        3'd0, 3'd1: spm_write(spm_index_t'(take_bits(4) * 32'd17));
        3'd2, 3'd3: spm_read(spm_index_t'(take_bits(4) * 32'd17));
        3'd4: reg_write((take_bits(2) == 0) ? 10'(take_bits(10)) : 10'(take_bits(3)));
        3'd5: reg_read((take_bits(2) == 0) ? 10'(take_bits(10)) : 10'(take_bits(3)));
        default: bad_access();
      endcase
      check_ratios();
    end

    // Sweep of all touched state
    for (int i = 0; i < 5; i++) begin
      reg_read(10'(i));
    end
    for (int i = 0; i < 16; i++) begin
      spm_read(spm_index_t'(i * 17));
    end

    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    @(posedge clk);
    $display("Test passed");
    $finish;
  end

  initial begin
    #(clk_period * (reset_cycles + num_transfers * cycles_per_xfer));
    report_problem("watchdog expired before the test sequence finished");
  end

endmodule

`default_nettype wire
